// ==== files.f ====
+incdir+verif
design/exu_pkg.sv
design/exu_reg_file.sv
design/exu_alu.sv
design/exu_branch.sv
design/exu_ecl.sv
design/exec_unit.sv
verif/exec_unit_props.sv
verif/exec_unit_tb.sv

// ==== Makefile ====
TOP := exec_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir

// ==== verif/exec_unit_tests.svh ====
// load every register from r0, then each alu op in both operand forms
task automatic alu_op_sweep();
   test_name = "alu_ops";
   for (int r = 1; r < NUM_REGS; r++) begin
      send_op(add, r, 0, 0, 1'b1, grlen_t'(32'h9e37_79b9 * r));
   end
   for (int i = 0; i < 11; i++) begin
      send_op(exu_op_t'(i), 20 + i, 1 + i, 12 + i, 1'b0, '0);
      send_op(exu_op_t'(i), 21 + i, 2 + i, 0, 1'b1, grlen_t'(32'h0000_0f23 ^ (32'h1357 * i)));
   end
   idle_cycles(4);
endtask

task automatic bypass_chains();
   test_name = "bypass";
   // distance 1 with the producer still in E
   send_op(add, 5, 1, 2, 1'b0, '0);
   send_op(sub, 6, 5, 3, 1'b0, '0);
   send_op(xor_op, 7, 4, 6, 1'b0, '0);
   send_op(sll, 8, 7, 0, 1'b1, 32'd3);
   // one source from W and one from E
   send_op(or_op, 9, 2, 3, 1'b0, '0);
   send_op(add, 10, 1, 0, 1'b1, 32'h100);
   send_op(and_op, 11, 10, 9, 1'b0, '0);
   // same rd in E and W where the younger value wins
   send_op(add, 12, 0, 0, 1'b1, 32'h1111);
   send_op(add, 12, 0, 0, 1'b1, 32'h2222);
   send_op(add, 13, 12, 0, 1'b1, 32'h0);
   send_op(sra, 14, 13, 0, 1'b1, 32'd4);
   idle_cycles(1);
   send_op(add, 15, 14, 14, 1'b0, '0);
   idle_cycles(2);
   send_op(slt, 16, 15, 3, 1'b0, '0);
   idle_cycles(4);
endtask

task automatic zero_register();
   test_name = "zero_reg";
   send_op(add, 0, 1, 2, 1'b0, '0);
   send_op(add, 3, 0, 0, 1'b1, 32'h55);
   send_op(or_op, 0, 0, 0, 1'b1, 32'hffff_ffff);
   send_op(add, 4, 0, 0, 1'b0, '0);
   idle_cycles(3);
   send_op(sub, 5, 0, 0, 1'b0, '0);
   // rf_wen low writes nothing and forwards nothing
   send_op(add, 6, 0, 0, 1'b1, 32'h77, 1'b0);
   send_op(add, 7, 6, 0, 1'b1, '0);
   idle_cycles(4);
endtask

task automatic branch_cases();
   test_name = "branches";
   send_op(add, 1, 0, 0, 1'b1, 32'd5);
   send_op(add, 2, 0, 0, 1'b1, 32'd5);
   send_op(add, 3, 0, 0, 1'b1, 32'hffff_fffd);
   send_op(add, 4, 0, 0, 1'b1, 32'd7);
   // taken branches squash the add behind them and leave r9 as it was
   send_op(beq, 9, 1, 2, 1'b0, 32'h40);
   send_op(add, 10, 0, 0, 1'b1, 32'h1);
   send_op(bne, 9, 1, 4, 1'b0, 32'hffff_ff80);
   send_op(add, 10, 0, 0, 1'b1, 32'h2);
   send_op(blt, 9, 3, 1, 1'b0, 32'h8);
   send_op(add, 10, 0, 0, 1'b1, 32'h3);
   send_op(bge, 9, 4, 3, 1'b0, 32'h10);
   send_op(add, 10, 0, 0, 1'b1, 32'h4);
   // the follower of a branch not taken completes
   send_op(beq, 9, 1, 4, 1'b0, 32'h40);
   send_op(add, 11, 9, 0, 1'b1, 32'h5);
   send_op(bne, 9, 1, 2, 1'b0, 32'h40);
   send_op(add, 11, 11, 0, 1'b1, 32'h6);
   send_op(blt, 9, 4, 3, 1'b0, 32'h40);
   send_op(add, 11, 11, 0, 1'b1, 32'h7);
   send_op(bge, 9, 3, 1, 1'b0, 32'h40);
   send_op(add, 11, 11, 0, 1'b1, 32'h8);
   // jirl from r4 with the link into r14
   send_op(jirl, 14, 4, 0, 1'b0, 32'h100);
   send_op(add, 15, 0, 0, 1'b1, 32'h9);
   idle_cycles(1);
   send_op(add, 16, 14, 0, 1'b1, '0);
   // second taken branch sits in the squashed slot
   send_op(beq, 0, 1, 2, 1'b0, 32'h20);
   send_op(beq, 0, 1, 2, 1'b0, 32'h30);
   send_op(add, 17, 0, 0, 1'b1, 32'ha);
   idle_cycles(4);
endtask

task automatic random_stream();
   test_name = "random";
   for (int n = 0; n < RANDOM_COUNT; n++) begin
      send_op(exu_op_t'($unsigned($random(seed)) % 11), $unsigned($random(seed)) % 32,
              $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32,
              1'($random(seed)), grlen_t'($random(seed)));
      if (($random(seed) & 3) == 0) begin
         idle_cycles(1);
      end
   end
   idle_cycles(4);
endtask

// ==== verif/exec_unit_tb.sv ====
module exec_unit_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import exu_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_COUNT = 200;
   // random gaps add at most one cycle per instruction
   localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 30 + 20 + 40 + 2 * RANDOM_COUNT + 8;
   localparam int CYCLE_LIMIT  = TEST_CYCLES + 100;

   typedef struct packed {
      wb_t wb;
      int  at_edge;
   } exp_wb_t;

   typedef struct packed {
      redirect_t redirect;
      int        at_edge;
   } exp_redirect_t;

   logic          clk;
   logic          reset;
   logic          issue_valid;
   issue_t        issue;
   redirect_t     redirect;
   wb_t           wb;

   // in-order model state and the expected output streams
   grlen_t        shadow [NUM_REGS];
   exp_wb_t       exp_wb_q [$];
   exp_redirect_t exp_rd_q [$];
   int            cycle;
   int            taken_edge;
   int            mismatches;
   int            other_errors;
   int            seed;
   grlen_t        next_pc;
   string         test_name;

   exec_unit exec_unit_inst (
      .clk         (clk),
      .reset       (reset),
      .issue_valid (issue_valid),
      .issue       (issue),
      .redirect    (redirect),
      .wb          (wb)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle);
         other_errors++;
         finish_run();
      end
   end

   // outputs only change at the rising edge
   always @(negedge clk) begin
      if (!reset) begin
         watch_outputs();
      end
   end

   task automatic finish_run();
      $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   task automatic check_wb(input string name, input wb_t expected, input wb_t actual);
      if (actual !== expected) begin
         $display("mismatch %s wb: expected %0b/%0d/%h/%h, actual %0b/%0d/%h/%h", name,
                  expected.wen, expected.rd, expected.data, expected.pc,
                  actual.wen, actual.rd, actual.data, actual.pc);
         mismatches++;
      end
   endtask

   task automatic check_redirect(input string name, input redirect_t expected,
                                 input redirect_t actual);
      if (actual !== expected) begin
         $display("mismatch %s redirect: expected %0b/%h, actual %0b/%h", name,
                  expected.taken, expected.target, actual.taken, actual.target);
         mismatches++;
      end
   endtask

   function automatic grlen_t alu_ref(exu_op_t op, grlen_t a, grlen_t b);
      case (op)
         add:     return a + b;
         sub:     return a - b;
         and_op:  return a & b;
         or_op:   return a | b;
         xor_op:  return a ^ b;
         slt:     return {31'b0, $signed(a) < $signed(b)};
         sltu:    return {31'b0, a < b};
         sll:     return a << b[4:0];
         srl:     return a >> b[4:0];
         sra:     return grlen_t'($signed(a) >>> b[4:0]);
         lui:     return b;
         default: return '0;
      endcase
   endfunction

   function automatic logic branch_ref(exu_op_t op, grlen_t a, grlen_t b);
      case (op)
         beq:     return a == b;
         bne:     return a != b;
         blt:     return $signed(a) < $signed(b);
         bge:     return $signed(a) >= $signed(b);
         default: return 1'b1;
      endcase
   endfunction

   // drives one instruction and predicts its redirect and write-back
   task automatic send_op(input exu_op_t op, input int rd, input int rs1, input int rs2,
                          input logic use_imm, input grlen_t imm,
                          input logic write_en = 1'b1);
      issue_t        ins;
      grlen_t        a;
      grlen_t        b;
      grlen_t        result;
      logic          wen;
      exp_wb_t       exp_w;
      exp_redirect_t exp_rd;
      @(negedge clk);
      ins = '{pc: next_pc, op: op, rs1: reg_idx_t'(rs1), rs2: reg_idx_t'(rs2),
              rd: reg_idx_t'(rd), rf_wen: write_en, use_imm: use_imm, imm: imm};
      issue       = ins;
      issue_valid = 1'b1;
      next_pc     = next_pc + 32'd4;
      // slot right behind a taken branch never executes
      if (taken_edge == cycle) begin
         return;
      end
      a   = shadow[ins.rs1];
      b   = use_imm ? imm : shadow[ins.rs2];
      wen = write_en;
      if (op inside {beq, bne, blt, bge, jirl}) begin
         result = ins.pc + 32'd4;
         wen    = write_en && (op == jirl);
         if (branch_ref(op, a, shadow[ins.rs2])) begin
            exp_rd.redirect.taken  = 1'b1;
            exp_rd.redirect.target = (op == jirl) ? a + imm : ins.pc + imm;
            exp_rd.at_edge         = cycle + 1;
            exp_rd_q.push_back(exp_rd);
            taken_edge = cycle + 1;
         end
      end else begin
         result = alu_ref(op, a, b);
      end
      if (wen && ins.rd != '0) begin
         shadow[ins.rd] = result;
         exp_w.wb       = '{wen: 1'b1, rd: ins.rd, data: result, pc: ins.pc};
         exp_w.at_edge  = cycle + 1;
         exp_wb_q.push_back(exp_w);
      end
   endtask

   // invalid slots carry a live-looking rd to catch writes without valid
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         issue_valid  = 1'b0;
         issue.rd     = reg_idx_t'($random(seed));
         issue.rf_wen = 1'b1;
      end
   endtask

   task automatic watch_outputs();
      redirect_t     exp_rd;
      exp_redirect_t exp_r;
      exp_wb_t       exp_w;
      // target is a don't care without a taken branch in E
      exp_rd = '{taken: 1'b0, target: redirect.target};
      if (exp_rd_q.size() > 0 && exp_rd_q[0].at_edge == cycle) begin
         exp_r  = exp_rd_q.pop_front();
         exp_rd = exp_r.redirect;
      end
      check_redirect(test_name, exp_rd, redirect);
      while (exp_wb_q.size() > 0 && exp_wb_q[0].at_edge + 2 < cycle + 1) begin
         exp_w = exp_wb_q.pop_front();
         $display("%s: expected write-back for pc %h never appeared", test_name, exp_w.wb.pc);
         other_errors++;
      end
      if (wb.wen) begin
         if (exp_wb_q.size() == 0) begin
            $display("%s: write-back to r%0d that the model did not predict", test_name, wb.rd);
            other_errors++;
         end else begin
            exp_w = exp_wb_q.pop_front();
            check_wb(test_name, exp_w.wb, wb);
            if (cycle + 1 - exp_w.at_edge != 2) begin
               $display("%s: write-back for pc %h came %0d cycles after issue, not 2",
                        test_name, wb.pc, cycle + 1 - exp_w.at_edge);
               other_errors++;
            end
         end
      end
   endtask

   `include "exec_unit_tests.svh"

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      issue_valid  = 1'b0;
      issue        = '0;
      cycle        = 0;
      taken_edge   = -10;
      mismatches   = 0;
      other_errors = 0;
      seed         = 37;
      next_pc      = 32'h0000_1000;
      test_name    = "reset";
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      alu_op_sweep();
      bypass_chains();
      zero_register();
      branch_cases();
      random_stream();
      idle_cycles(3);
      if (exp_wb_q.size() != 0 || exp_rd_q.size() != 0) begin
         $display("%0d write-backs and %0d redirects still outstanding at the end",
                  exp_wb_q.size(), exp_rd_q.size());
         other_errors++;
      end
      finish_run();
   end

endmodule

// ==== verif/exec_unit_props.sv ====
module exec_unit_props (
   input logic               clk,
   input logic               reset,
   input exu_pkg::redirect_t redirect,
   input exu_pkg::wb_t       wb
);
   timeunit 1ns;
   timeprecision 100ps;

   // pipeline comes out of reset empty
   redirect_idle_after_reset: assert property (@(posedge clk) reset |=> !redirect.taken)
      else $error("redirect taken in the cycle after reset");

   wb_never_r0: assert property (@(posedge clk) disable iff (reset) wb.wen |-> wb.rd != '0)
      else $error("write-back enabled with rd zero");

   // slot behind a taken branch is squashed, so no second pulse
   single_cycle_redirect: assert property (
      @(posedge clk) disable iff (reset) redirect.taken |=> !redirect.taken)
      else $error("redirect held for two cycles");

endmodule

bind exu_ecl exec_unit_props props_inst (
   .clk      (clk),
   .reset    (reset),
   .redirect (redirect),
   .wb       (wb)
);

// ==== design/exec_unit.sv ====
module exec_unit (
   input  logic               clk,
   input  logic               reset,
   input  logic               issue_valid,
   input  exu_pkg::issue_t    issue,
   output exu_pkg::redirect_t redirect,
   output exu_pkg::wb_t       wb
);
   import exu_pkg::*;

   reg_idx_t rs1_idx;
   reg_idx_t rs2_idx;
   grlen_t   rs1_data;
   grlen_t   rs2_data;

   grlen_t   alu_a;
   grlen_t   alu_b;
   alu_op_t  alu_op;
   grlen_t   alu_result;

   bru_op_t  bru_op;
   grlen_t   bru_a;
   grlen_t   bru_b;
   grlen_t   bru_pc;
   grlen_t   bru_offset;
   logic     bru_taken;
   grlen_t   bru_target;
   grlen_t   bru_link;

   exu_ecl ecl (
      .clk         (clk         ),
      .reset       (reset       ),
      .issue_valid (issue_valid ),
      .issue       (issue       ),
      .rs1_idx     (rs1_idx     ),
      .rs2_idx     (rs2_idx     ),
      .rs1_data    (rs1_data    ),
      .rs2_data    (rs2_data    ),
      .alu_a       (alu_a       ),
      .alu_b       (alu_b       ),
      .alu_op      (alu_op      ),
      .alu_result  (alu_result  ),
      .bru_op      (bru_op      ),
      .bru_a       (bru_a       ),
      .bru_b       (bru_b       ),
      .bru_pc      (bru_pc      ),
      .bru_offset  (bru_offset  ),
      .bru_taken   (bru_taken   ),
      .bru_target  (bru_target  ),
      .bru_link    (bru_link    ),
      .redirect    (redirect    ),
      .wb          (wb          )
   );

   // write port fed straight from the W stage
   exu_reg_file registers (
      .clk    (clk      ),
      .raddr1 (rs1_idx  ),
      .raddr2 (rs2_idx  ),
      .rdata1 (rs1_data ),
      .rdata2 (rs2_data ),
      .wr     (wb       )
   );

   exu_alu alu (
      .a      (alu_a      ),
      .b      (alu_b      ),
      .op     (alu_op     ),
      .result (alu_result )
   );

   exu_branch bru (
      .op     (bru_op     ),
      .a      (bru_a      ),
      .b      (bru_b      ),
      .pc     (bru_pc     ),
      .offset (bru_offset ),
      .taken  (bru_taken  ),
      .target (bru_target ),
      .link   (bru_link   )
   );

endmodule

// ==== design/exu_ecl.sv ====
module exu_ecl (
   input  logic               clk,
   input  logic               reset,
   input  logic               issue_valid,
   input  exu_pkg::issue_t    issue,

   output exu_pkg::reg_idx_t  rs1_idx,
   output exu_pkg::reg_idx_t  rs2_idx,
   input  exu_pkg::grlen_t    rs1_data,
   input  exu_pkg::grlen_t    rs2_data,

   output exu_pkg::grlen_t    alu_a,
   output exu_pkg::grlen_t    alu_b,
   output exu_pkg::alu_op_t   alu_op,
   input  exu_pkg::grlen_t    alu_result,

   output exu_pkg::bru_op_t   bru_op,
   output exu_pkg::grlen_t    bru_a,
   output exu_pkg::grlen_t    bru_b,
   output exu_pkg::grlen_t    bru_pc,
   output exu_pkg::grlen_t    bru_offset,
   input  logic               bru_taken,
   input  exu_pkg::grlen_t    bru_target,
   input  exu_pkg::grlen_t    bru_link,

   output exu_pkg::redirect_t redirect,
   output exu_pkg::wb_t       wb
);
   import exu_pkg::*;

   // operands are resolved in D and carried into E
   typedef struct packed {
      grlen_t   pc;
      exu_op_t  op;
      reg_idx_t rd;
      logic     rf_wen;
      grlen_t   src1;
      grlen_t   src2;
      grlen_t   opnd_b;
      grlen_t   imm;
   } e_stage_t;

   e_stage_t e_q;
   e_stage_t d_next;
   logic     e_valid;
   logic     e_is_br;
   logic     e_is_cond;
   logic     e_wen;
   logic     e_taken;
   grlen_t   e_result;
   grlen_t   d_src1;
   grlen_t   d_src2;

   assign rs1_idx = issue.rs1;
   assign rs2_idx = issue.rs2;

   // E result first, then W, then the register file
   // e_wen and wb.wen are never set for r0, so r0 is not forwarded
   assign d_src1 = (e_wen && (issue.rs1 == e_q.rd)) ? e_result :
                   (wb.wen && (issue.rs1 == wb.rd)) ? wb.data : rs1_data;
   assign d_src2 = (e_wen && (issue.rs2 == e_q.rd)) ? e_result :
                   (wb.wen && (issue.rs2 == wb.rd)) ? wb.data : rs2_data;

   always_comb begin
      d_next.pc     = issue.pc;
      d_next.op     = issue.op;
      d_next.rd     = issue.rd;
      d_next.rf_wen = issue.rf_wen;
      d_next.src1   = d_src1;
      d_next.src2   = d_src2;
      d_next.opnd_b = issue.use_imm ? issue.imm : d_src2;
      d_next.imm    = issue.imm;
   end

   // split the issued opcode between alu and branch unit
   always_comb begin
      alu_op = alu_add;
      bru_op = bru_beq;
      case (e_q.op)
         add:     alu_op = alu_add;
         sub:     alu_op = alu_sub;
         and_op:  alu_op = alu_and;
         or_op:   alu_op = alu_or;
         xor_op:  alu_op = alu_xor;
         slt:     alu_op = alu_slt;
         sltu:    alu_op = alu_sltu;
         sll:     alu_op = alu_sll;
         srl:     alu_op = alu_srl;
         sra:     alu_op = alu_sra;
         lui:     alu_op = alu_lui;
         beq:     bru_op = bru_beq;
         bne:     bru_op = bru_bne;
         blt:     bru_op = bru_blt;
         bge:     bru_op = bru_bge;
         jirl:    bru_op = bru_jirl;
         default: alu_op = alu_add;
      endcase
   end

   assign alu_a      = e_q.src1;
   assign alu_b      = e_q.opnd_b;
   assign bru_a      = e_q.src1;
   assign bru_b      = e_q.src2;
   assign bru_pc     = e_q.pc;
   assign bru_offset = e_q.imm;

   assign e_is_br   = e_q.op inside {beq, bne, blt, bge, jirl};
   assign e_is_cond = e_is_br && (e_q.op != jirl);
   assign e_taken   = e_valid && e_is_br && bru_taken;
   assign e_result  = (e_q.op == jirl) ? bru_link : alu_result;

   // conditional branches never write, whatever rf_wen says
   assign e_wen = e_valid && e_q.rf_wen && !e_is_cond && (e_q.rd != '0);

   assign redirect.taken  = e_taken;
   assign redirect.target = bru_target;

   always_ff @(posedge clk) begin
      e_q     <= d_next;
      wb.rd   <= e_q.rd;
      wb.data <= e_result;
      wb.pc   <= e_q.pc;
      if (reset) begin
         e_valid <= 1'b0;
         wb.wen  <= 1'b0;
      end else begin
         // slot behind a taken branch is dropped
         e_valid <= issue_valid && !e_taken;
         wb.wen  <= e_wen;
      end
   end

endmodule

// ==== design/exu_branch.sv ====
module exu_branch (
   input  exu_pkg::bru_op_t op,
   input  exu_pkg::grlen_t  a,
   input  exu_pkg::grlen_t  b,
   input  exu_pkg::grlen_t  pc,
   input  exu_pkg::grlen_t  offset,
   output logic             taken,
   output exu_pkg::grlen_t  target,
   output exu_pkg::grlen_t  link
);
   import exu_pkg::*;

   logic equal;
   logic less;

   assign equal = (a == b);
   assign less  = $signed(a) < $signed(b);

   always_comb begin
      case (op)
         bru_beq: begin
            taken = equal;
         end
         bru_bne: begin
            taken = !equal;
         end
         bru_blt: begin
            taken = less;
         end
         bru_bge: begin
            taken = !less;
         end
         // jump is unconditional
         bru_jirl: begin
            taken = 1'b1;
         end
         default: begin
            taken = 1'b0;
         end
      endcase
   end

   // jirl jumps relative to its register, others relative to pc
   assign target = (op == bru_jirl) ? (a + offset) : (pc + offset);

   // return address for jirl
   assign link = pc + grlen_t'(INST_BYTES);

endmodule

// ==== design/exu_alu.sv ====
module exu_alu (
   input  exu_pkg::grlen_t  a,
   input  exu_pkg::grlen_t  b,
   input  exu_pkg::alu_op_t op,
   output exu_pkg::grlen_t  result
);
   import exu_pkg::*;

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   // only the low bits of b count for shifts
   assign shamt       = b[4:0];
   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         alu_add: begin
            result = a + b;
         end
         alu_sub: begin
            result = a - b;
         end
         alu_and: begin
            result = a & b;
         end
         alu_or: begin
            result = a | b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         alu_slt: begin
            result = {{(GRLEN-1){1'b0}}, lt_signed};
         end
         alu_sltu: begin
            result = {{(GRLEN-1){1'b0}}, lt_unsigned};
         end
         alu_sll: begin
            result = a << shamt;
         end
         alu_srl: begin
            result = a >> shamt;
         end
         alu_sra: begin
            result = grlen_t'($signed(a) >>> shamt);
         end
         // immediate comes in on b
         alu_lui: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// ==== design/exu_reg_file.sv ====
module exu_reg_file (
   input  logic              clk,

   input  exu_pkg::reg_idx_t raddr1,
   input  exu_pkg::reg_idx_t raddr2,
   output exu_pkg::grlen_t   rdata1,
   output exu_pkg::grlen_t   rdata2,

   input  exu_pkg::wb_t      wr
);
   import exu_pkg::*;

   grlen_t regs [NUM_REGS];

   // r0 is never stored, reads below force it to zero
   always_ff @(posedge clk) begin
      if (wr.wen && (wr.rd != '0)) begin
         regs[wr.rd] <= wr.data;
      end
   end

   always_comb begin
      if (raddr1 == '0) begin
         rdata1 = '0;
      end else begin
         rdata1 = regs[raddr1];
      end
   end

   always_comb begin
      if (raddr2 == '0) begin
         rdata2 = '0;
      end else begin
         rdata2 = regs[raddr2];
      end
   end

endmodule

// ==== design/exu_pkg.sv ====
package exu_pkg;

   localparam int GRLEN      = 32;
   localparam int NUM_REGS   = 32;
   localparam int REG_IDX_W  = 5;
   localparam int INST_BYTES = 4;

   typedef logic [GRLEN-1:0]     grlen_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // opcodes as delivered by decode, alu ops first
   typedef enum logic [3:0] {
      add,
      sub,
      and_op,
      or_op,
      xor_op,
      slt,
      sltu,
      sll,
      srl,
      sra,
      lui,
      beq,
      bne,
      blt,
      bge,
      jirl
   } exu_op_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
      alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
   } alu_op_t;

   typedef enum logic [2:0] {
      bru_beq, bru_bne, bru_blt, bru_bge, bru_jirl
   } bru_op_t;

   // one pre-decoded instruction from the front end
   typedef struct packed {
      grlen_t   pc;
      exu_op_t  op;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      logic     rf_wen;
      logic     use_imm;
      grlen_t   imm;
   } issue_t;

   typedef struct packed {
      logic   taken;
      grlen_t target;
   } redirect_t;

   // write-back trace, doubles as the register file write port
   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      grlen_t   data;
      grlen_t   pc;
   } wb_t;

endpackage
